/* exec_stage.f */
src/exec_pkg.sv
src/exec_alu.sv
src/exec_stack_addr.sv
src/exec_sequencer.sv
src/exec_stage.sv
tb/exec_stage_properties.sv
tb/exec_stage_tb.sv

/* src/exec_alu.sv */
// Pure combinational result; writes_reg_o is low for every opcode outside the register group
`timescale 1ns/1ps

module exec_alu (
  input  exec_pkg::opcode_t op_i,
  input  exec_pkg::word_t   reg_a_i,
  input  exec_pkg::word_t   reg_b_i,
  input  exec_pkg::word_t   operand_i,
  output exec_pkg::word_t   result_o,
  output logic              writes_reg_o
);
  import exec_pkg::*;

  always_comb
  begin
    result_o     = '0;
    writes_reg_o = 1'b1;
    case (op_i)
      OP_ADD_L:
        result_o = reg_a_i + reg_b_i;
      OP_SUB_L:
        result_o = reg_a_i - reg_b_i;
      OP_AND:
        result_o = reg_a_i & reg_b_i;
      OP_OR:
        result_o = reg_a_i | reg_b_i;
      OP_XOR:
        result_o = reg_a_i ^ reg_b_i;
      OP_MOV:
        result_o = reg_b_i;
      // Increment and decrement take their step from the operand
      OP_INC:
        result_o = reg_a_i + operand_i;
      OP_DEC:
        result_o = reg_a_i - operand_i;
      OP_LDI_L:
        result_o = operand_i;
      OP_NOP:
        writes_reg_o = 1'b0;
      // Memory, stack and jump opcodes are handled elsewhere
      default:
        writes_reg_o = 1'b0;
    endcase
  end

endmodule

/* src/exec_pkg.sv */
// Opcode values follow the decoder's 6-bit encoding; any code not listed here executes as NOP
package exec_pkg;

  // Data, address and program-counter word
  typedef logic [31:0] word_t;

  // Register file index
  typedef logic [3:0] reg_idx_t;

  // Decoded operation code
  typedef logic [5:0] opcode_t;

  // Register and immediate operations
  localparam opcode_t OP_NOP   = 6'h0f;
  localparam opcode_t OP_LDI_L = 6'h01;
  localparam opcode_t OP_MOV   = 6'h02;
  localparam opcode_t OP_ADD_L = 6'h05;
  localparam opcode_t OP_AND   = 6'h26;
  localparam opcode_t OP_SUB_L = 6'h29;
  localparam opcode_t OP_OR    = 6'h2b;
  localparam opcode_t OP_XOR   = 6'h2e;
  localparam opcode_t OP_INC   = 6'h38;
  localparam opcode_t OP_DEC   = 6'h39;

  // Memory and stack operations
  localparam opcode_t OP_PUSH  = 6'h06;
  localparam opcode_t OP_POP   = 6'h07;
  localparam opcode_t OP_LDA_L = 6'h08;
  localparam opcode_t OP_STA_L = 6'h09;

  // Control flow
  localparam opcode_t OP_RET   = 6'h04;
  localparam opcode_t OP_JSR   = 6'h19;
  localparam opcode_t OP_JMPA  = 6'h1a;
  localparam opcode_t OP_JMP   = 6'h25;

  // Register holding the stack pointer
  localparam reg_idx_t SP_INDEX = 4'd1;

  // One stack slot
  localparam word_t WORD_BYTES = 32'd4;

  // Return address plus saved frame pointer
  localparam word_t FRAME_BYTES = 32'd8;

  // Call instruction length, so PC plus this is the return address
  localparam word_t JSR_INSN_BYTES = 32'd6;

  // Call and return each take a second cycle to handle the frame word
  typedef enum logic [1:0] {
    READY      = 2'd0,
    CALL_FRAME = 2'd1,
    RET_FRAME  = 2'd2
  } exec_state_e;

endpackage

/* src/exec_sequencer.sv */
// stall_i holds state and results and drops the strobes; op_i must stay stable while stall_o is high
`timescale 1ns/1ps

module exec_sequencer (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  stall_i,
  input  exec_pkg::opcode_t     op_i,
  input  exec_pkg::word_t       operand_i,
  input  exec_pkg::word_t       reg_a_i,
  input  exec_pkg::reg_idx_t    wr_index_i,
  input  exec_pkg::word_t       alu_result_i,
  input  logic                  alu_writes_i,
  input  exec_pkg::word_t       sa_addr_i,
  input  exec_pkg::word_t       sa_data_i,
  input  exec_pkg::word_t       sa_result_i,
  input  logic                  sa_rd_i,
  input  logic                  sa_wr_i,
  input  logic                  sa_writes_i,
  input  logic                  sa_sp_i,
  output exec_pkg::exec_state_e state_o,
  output exec_pkg::reg_idx_t    reg_wr_index_o,
  output logic                  reg_wr_en_o,
  output exec_pkg::word_t       reg_result_o,
  output logic                  mem_rd_en_o,
  output logic                  mem_wr_en_o,
  output exec_pkg::word_t       mem_addr_o,
  output exec_pkg::word_t       mem_data_o,
  output logic                  stall_o,
  output logic                  branch_o,
  output exec_pkg::word_t       branch_target_o
);
  import exec_pkg::*;

  exec_state_e state;
  exec_state_e next_state;
  logic        ready;
  logic        is_jump;
  logic        take_branch;
  logic        alu_writes;
  word_t       next_target;

  assign state_o = state;
  assign ready   = (state == READY);

  // Register ops are only accepted from READY
  assign alu_writes = ready & alu_writes_i;

  assign is_jump     = ready && ((op_i == OP_JMP) || (op_i == OP_JMPA));
  assign take_branch = is_jump || (state == CALL_FRAME);

  // JMP goes through a register, JMPA and the call use the operand
  assign next_target = (ready && (op_i == OP_JMP)) ? reg_a_i : operand_i;

  always_comb
  begin
    next_state = READY;
    case (state)
      READY:
        if (op_i == OP_JSR)
        begin
          next_state = CALL_FRAME;
        end
        else if (op_i == OP_RET)
        begin
          next_state = RET_FRAME;
        end
        else
        begin
          next_state = READY;
        end
      // Both frame cycles always finish in one step
      CALL_FRAME:
        next_state = READY;
      RET_FRAME:
        next_state = READY;
      default:
        next_state = READY;
    endcase
  end

  // Control state and strobes
  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      state       <= READY;
      stall_o     <= 1'b0;
      reg_wr_en_o <= 1'b0;
      mem_rd_en_o <= 1'b0;
      mem_wr_en_o <= 1'b0;
      branch_o    <= 1'b0;
    end
    else if (stall_i)
    begin
      // State and stall_o hold, strobes are withdrawn
      reg_wr_en_o <= 1'b0;
      mem_rd_en_o <= 1'b0;
      mem_wr_en_o <= 1'b0;
      branch_o    <= 1'b0;
    end
    else
    begin
      state       <= next_state;
      stall_o     <= (next_state != READY);
      reg_wr_en_o <= alu_writes | sa_writes_i;
      mem_rd_en_o <= sa_rd_i;
      mem_wr_en_o <= sa_wr_i;
      branch_o    <= take_branch;
    end
  end

  // Result payload
  always_ff @(posedge clk_i)
  begin
    if (!stall_i)
    begin
      reg_wr_index_o <= sa_sp_i ? SP_INDEX : wr_index_i;
      reg_result_o   <= sa_writes_i ? sa_result_i : alu_result_i;
      mem_addr_o     <= sa_addr_i;
      mem_data_o     <= sa_data_i;
      // Target stays put between branches
      if (take_branch)
      begin
        branch_target_o <= next_target;
      end
    end
  end

endmodule

/* src/exec_stack_addr.sv */
// Pure combinational; frame states override op_i, which upstream holds during a call or return
`timescale 1ns/1ps

module exec_stack_addr (
  input  exec_pkg::opcode_t     op_i,
  input  exec_pkg::exec_state_e state_i,
  input  exec_pkg::word_t       reg_a_i,
  input  exec_pkg::word_t       reg_b_i,
  input  exec_pkg::word_t       operand_i,
  input  exec_pkg::word_t       sp_i,
  input  exec_pkg::word_t       fp_i,
  input  exec_pkg::word_t       pc_i,
  output exec_pkg::word_t       mem_addr_o,
  output exec_pkg::word_t       mem_data_o,
  output exec_pkg::word_t       reg_result_o,
  output logic                  mem_rd_o,
  output logic                  mem_wr_o,
  output logic                  writes_reg_o,
  output logic                  writes_sp_o
);
  import exec_pkg::*;

  always_comb
  begin
    mem_addr_o   = '0;
    mem_data_o   = '0;
    reg_result_o = '0;
    mem_rd_o     = 1'b0;
    mem_wr_o     = 1'b0;
    writes_reg_o = 1'b0;
    writes_sp_o  = 1'b0;
    case (state_i)
      // Second call cycle saves the frame pointer below the return address
      CALL_FRAME:
      begin
        mem_addr_o   = sp_i - WORD_BYTES;
        mem_data_o   = fp_i;
        reg_result_o = sp_i - WORD_BYTES;
        {mem_wr_o, writes_reg_o, writes_sp_o} = 3'b111;
      end
      RET_FRAME:
      begin
        mem_addr_o   = sp_i + WORD_BYTES;
        reg_result_o = sp_i + WORD_BYTES;
        {mem_rd_o, writes_reg_o, writes_sp_o} = 3'b111;
      end
      default:
        case (op_i)
          OP_LDA_L:
          begin
            mem_addr_o = operand_i;
            mem_rd_o   = 1'b1;
          end
          OP_STA_L:
          begin
            mem_addr_o = operand_i;
            mem_data_o = reg_a_i;
            mem_wr_o   = 1'b1;
          end
          // reg_a_i is the pointer register, which takes the new address
          OP_PUSH:
          begin
            mem_addr_o   = reg_a_i - WORD_BYTES;
            mem_data_o   = reg_b_i;
            reg_result_o = reg_a_i - WORD_BYTES;
            {mem_wr_o, writes_reg_o} = 2'b11;
          end
          OP_POP:
          begin
            mem_addr_o   = reg_a_i;
            reg_result_o = reg_a_i + WORD_BYTES;
            {mem_rd_o, writes_reg_o} = 2'b11;
          end
          OP_JSR:
          begin
            mem_addr_o   = sp_i - FRAME_BYTES;
            mem_data_o   = pc_i + JSR_INSN_BYTES;
            reg_result_o = sp_i - FRAME_BYTES;
            {mem_wr_o, writes_reg_o, writes_sp_o} = 3'b111;
          end
          OP_RET:
          begin
            mem_addr_o   = sp_i;
            reg_result_o = sp_i + FRAME_BYTES;
            {mem_rd_o, writes_reg_o, writes_sp_o} = 3'b111;
          end
          default:
            mem_rd_o = 1'b0;
        endcase
    endcase
  end

endmodule

/* src/exec_stage.sv */
// All outputs are registered with one cycle latency; JSR and RET occupy the stage for two cycles
`timescale 1ns/1ps

module exec_stage (
  input  logic               clk_i,
  input  logic               rst_i,
  input  logic               stall_i,
  input  exec_pkg::opcode_t  op_i,
  input  exec_pkg::word_t    operand_i,
  input  exec_pkg::word_t    reg_a_i,
  input  exec_pkg::word_t    reg_b_i,
  input  exec_pkg::reg_idx_t wr_index_i,
  input  exec_pkg::word_t    sp_i,
  input  exec_pkg::word_t    fp_i,
  input  exec_pkg::word_t    pc_i,
  output exec_pkg::reg_idx_t reg_wr_index_o,
  output logic               reg_wr_en_o,
  output exec_pkg::word_t    reg_result_o,
  output logic               mem_rd_en_o,
  output logic               mem_wr_en_o,
  output exec_pkg::word_t    mem_addr_o,
  output exec_pkg::word_t    mem_data_o,
  output logic               stall_o,
  output logic               branch_o,
  output exec_pkg::word_t    branch_target_o
);
  import exec_pkg::*;

  word_t       alu_result;
  logic        alu_writes;
  word_t       sa_addr;
  word_t       sa_data;
  word_t       sa_result;
  logic        sa_rd;
  logic        sa_wr;
  logic        sa_writes;
  logic        sa_sp;
  exec_state_e state;

  exec_alu exec_alu_inst (
    .op_i         (op_i),
    .reg_a_i      (reg_a_i),
    .reg_b_i      (reg_b_i),
    .operand_i    (operand_i),
    .result_o     (alu_result),
    .writes_reg_o (alu_writes)
  );

  exec_stack_addr exec_stack_addr_inst (
    .op_i         (op_i),
    .state_i      (state),
    .reg_a_i      (reg_a_i),
    .reg_b_i      (reg_b_i),
    .operand_i    (operand_i),
    .sp_i         (sp_i),
    .fp_i         (fp_i),
    .pc_i         (pc_i),
    .mem_addr_o   (sa_addr),
    .mem_data_o   (sa_data),
    .reg_result_o (sa_result),
    .mem_rd_o     (sa_rd),
    .mem_wr_o     (sa_wr),
    .writes_reg_o (sa_writes),
    .writes_sp_o  (sa_sp)
  );

  exec_sequencer exec_sequencer_inst (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .stall_i         (stall_i),
    .op_i            (op_i),
    .operand_i       (operand_i),
    .reg_a_i         (reg_a_i),
    .wr_index_i      (wr_index_i),
    .alu_result_i    (alu_result),
    .alu_writes_i    (alu_writes),
    .sa_addr_i       (sa_addr),
    .sa_data_i       (sa_data),
    .sa_result_i     (sa_result),
    .sa_rd_i         (sa_rd),
    .sa_wr_i         (sa_wr),
    .sa_writes_i     (sa_writes),
    .sa_sp_i         (sa_sp),
    .state_o         (state),
    .reg_wr_index_o  (reg_wr_index_o),
    .reg_wr_en_o     (reg_wr_en_o),
    .reg_result_o    (reg_result_o),
    .mem_rd_en_o     (mem_rd_en_o),
    .mem_wr_en_o     (mem_wr_en_o),
    .mem_addr_o      (mem_addr_o),
    .mem_data_o      (mem_data_o),
    .stall_o         (stall_o),
    .branch_o        (branch_o),
    .branch_target_o (branch_target_o)
  );

endmodule

/* tb/exec_stage_properties.sv */
// Protocol checks on the top-level ports; stall_o may stay high only across stalled edges
`timescale 1ns/1ps

module exec_stage_properties (
  input logic clk_i,
  input logic rst_i,
  input logic stall_i,
  input logic reg_wr_en_i,
  input logic mem_rd_en_i,
  input logic mem_wr_en_i,
  input logic stall_out_i,
  input logic branch_i
);

  int unsigned failures = 0;

  // The memory stage takes one access per cycle
  mem_exclusive: assert property (@(posedge clk_i) disable iff (rst_i)
    !(mem_rd_en_i && mem_wr_en_i))
  else
  begin
    failures++;
    $error("memory read and write enables are high together");
  end

  // A frame cycle always completes on the next unstalled edge
  stall_single: assert property (@(posedge clk_i) disable iff (rst_i)
    (stall_out_i && !stall_i) |=> !stall_out_i)
  else
  begin
    failures++;
    $error("stall_o stayed high across an unstalled edge");
  end

  branch_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
    branch_i |=> !branch_i)
  else
  begin
    failures++;
    $error("branch_o stayed high for more than one cycle");
  end

  reset_quiet: assert property (@(posedge clk_i)
    rst_i |-> !(reg_wr_en_i || mem_rd_en_i || mem_wr_en_i || stall_out_i || branch_i))
  else
  begin
    failures++;
    $error("a control output is high during reset");
  end

endmodule

bind exec_stage exec_stage_properties protocol_checks (
  .clk_i       (clk_i),
  .rst_i       (rst_i),
  .stall_i     (stall_i),
  .reg_wr_en_i (reg_wr_en_o),
  .mem_rd_en_i (mem_rd_en_o),
  .mem_wr_en_i (mem_wr_en_o),
  .stall_out_i (stall_o),
  .branch_i    (branch_o)
);

/* tb/exec_stage_tb.sv */
// Outputs are compared 1 ns after each edge; payloads only where an enable or a hold defines them
`timescale 1ns/1ps

module exec_stage_tb;
  import exec_pkg::*;

  localparam int ALU_ROUNDS   = 4;
  localparam int RESET_CYCLES = 16;
  localparam int PLANNED_OPS  = ALU_ROUNDS * 20 + 30;
  localparam opcode_t SINGLE_OPS [0:19] = '{
    OP_ADD_L, OP_SUB_L, OP_AND, OP_OR, OP_XOR, OP_MOV, OP_INC, OP_DEC, OP_LDI_L,
    OP_NOP, 6'h00, 6'h3f, OP_LDA_L, OP_STA_L, OP_PUSH, OP_POP,
    OP_JMP, OP_NOP, OP_JMPA, OP_NOP
  };

  logic     clk = 1'b0;
  logic     rst = 1'b0;
  logic     stall = 1'b0;
  opcode_t  op = OP_NOP;
  word_t    operand = '0;
  word_t    reg_a = '0;
  word_t    reg_b = '0;
  reg_idx_t wr_index = '0;
  word_t    sp = '0;
  word_t    fp = '0;
  word_t    pc = '0;
  reg_idx_t reg_wr_index;
  logic     reg_wr_en;
  word_t    reg_result;
  logic     mem_rd_en;
  logic     mem_wr_en;
  word_t    mem_addr;
  word_t    mem_data;
  logic     stall_out;
  logic     branch;
  word_t    branch_target;

  // Expected outputs and the c_ flags that select which payloads are compared
  logic     e_wr_en, e_rd, e_wr, e_stall, e_br;
  logic     c_reg, c_addr, c_data, c_tgt;
  reg_idx_t e_idx;
  word_t    e_res, e_addr, e_data, e_tgt;
  word_t    rand_state = 32'd48468;

  exec_stage exec_stage_inst (
    .clk_i           (clk),
    .rst_i           (rst),
    .stall_i         (stall),
    .op_i            (op),
    .operand_i       (operand),
    .reg_a_i         (reg_a),
    .reg_b_i         (reg_b),
    .wr_index_i      (wr_index),
    .sp_i            (sp),
    .fp_i            (fp),
    .pc_i            (pc),
    .reg_wr_index_o  (reg_wr_index),
    .reg_wr_en_o     (reg_wr_en),
    .reg_result_o    (reg_result),
    .mem_rd_en_o     (mem_rd_en),
    .mem_wr_en_o     (mem_wr_en),
    .mem_addr_o      (mem_addr),
    .mem_data_o      (mem_data),
    .stall_o         (stall_out),
    .branch_o        (branch),
    .branch_target_o (branch_target)
  );

  always #10 clk = ~clk;

  function automatic word_t lcg_next();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return rand_state;
  endfunction

  task automatic stop_failed();
    $display("Done: errors found");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input word_t exp, input word_t act);
    $display("[FAIL] %s expected 0x%h actual 0x%h", name, exp, act);
    stop_failed();
  endtask

  task automatic check_value(input string name, input word_t exp, input word_t act);
    assert (act === exp) else report_mismatch(name, exp, act);
  endtask

  task automatic clear_expect();
    {e_wr_en, e_rd, e_wr, e_stall, e_br} = '0;
    {c_reg, c_addr, c_data, c_tgt} = '0;
  endtask

  // One clock edge, compare, then return 2 ns after the edge for the next drive
  task automatic step();
    @(posedge clk);
    #1;
    check_value("reg_wr_en_o", e_wr_en, reg_wr_en);
    check_value("mem_rd_en_o", e_rd, mem_rd_en);
    check_value("mem_wr_en_o", e_wr, mem_wr_en);
    check_value("stall_o", e_stall, stall_out);
    check_value("branch_o", e_br, branch);
    if (c_reg)
    begin
      check_value("reg_wr_index_o", e_idx, reg_wr_index);
      check_value("reg_result_o", e_res, reg_result);
    end
    if (c_addr)
      check_value("mem_addr_o", e_addr, mem_addr);
    if (c_data)
      check_value("mem_data_o", e_data, mem_data);
    if (c_tgt)
      check_value("branch_target_o", e_tgt, branch_target);
    #1;
  endtask

  task automatic randomize_inputs();
    word_t r;
    r = lcg_next();
    wr_index = r[27:24];
    operand = lcg_next();
    reg_a = lcg_next();
    reg_b = lcg_next();
    sp = lcg_next() & ~32'd3;
    fp = lcg_next();
    pc = lcg_next();
  endtask

  // Single-cycle operations, including NOP and unknown codes
  task automatic run_single(input opcode_t o);
    randomize_inputs();
    op = o;
    clear_expect();
    e_idx = wr_index;
    case (o)
      OP_ADD_L: {e_wr_en, c_reg, e_res} = {2'b11, reg_a + reg_b};
      OP_SUB_L: {e_wr_en, c_reg, e_res} = {2'b11, reg_a - reg_b};
      OP_AND:   {e_wr_en, c_reg, e_res} = {2'b11, reg_a & reg_b};
      OP_OR:    {e_wr_en, c_reg, e_res} = {2'b11, reg_a | reg_b};
      OP_XOR:   {e_wr_en, c_reg, e_res} = {2'b11, reg_a ^ reg_b};
      OP_MOV:   {e_wr_en, c_reg, e_res} = {2'b11, reg_b};
      OP_INC:   {e_wr_en, c_reg, e_res} = {2'b11, reg_a + operand};
      OP_DEC:   {e_wr_en, c_reg, e_res} = {2'b11, reg_a - operand};
      OP_LDI_L: {e_wr_en, c_reg, e_res} = {2'b11, operand};
      OP_LDA_L: {e_rd, c_addr, e_addr} = {2'b11, operand};
      OP_STA_L: {e_wr, c_addr, c_data, e_addr, e_data} = {3'b111, operand, reg_a};
      OP_PUSH:
        {e_wr, e_wr_en, c_reg, c_addr, c_data, e_addr, e_data, e_res} =
          {5'b11111, reg_a - 32'd4, reg_b, reg_a - 32'd4};
      OP_POP:
        {e_rd, e_wr_en, c_reg, c_addr, e_addr, e_res} = {4'b1111, reg_a, reg_a + 32'd4};
      OP_JMP:   {e_br, c_tgt, e_tgt} = {2'b11, reg_a};
      OP_JMPA:  {e_br, c_tgt, e_tgt} = {2'b11, operand};
      default:  e_br = 1'b0;
    endcase
    step();
  endtask

  // Stalled edges drop every strobe while state and payloads stay put
  task automatic hold_cycles(input int n);
    stall = 1'b1;
    {e_wr_en, e_rd, e_wr, e_br} = '0;
    repeat (n) step();
    stall = 1'b0;
  endtask

  // JSR or RET; the second cycle sees the stack pointer written by the first
  task automatic run_frame(input logic is_ret, input logic stall_mid);
    randomize_inputs();
    // Keep the requested index off SP_INDEX so the index switch is visible
    wr_index[1] = 1'b1;
    op = is_ret ? OP_RET : OP_JSR;
    clear_expect();
    {e_stall, e_wr_en, c_reg, c_addr, e_idx} = {4'b1111, 4'd1};
    if (is_ret)
      {e_rd, e_addr, e_res} = {1'b1, sp, sp + 32'd8};
    else
      {e_wr, c_data, e_addr, e_data, e_res} = {2'b11, sp - 32'd8, pc + 32'd6, sp - 32'd8};
    step();
    sp = e_res;
    if (stall_mid)
      hold_cycles(2);
    {e_stall, e_wr_en} = 2'b01;
    if (is_ret)
      {e_rd, e_addr, e_res} = {1'b1, sp + 32'd4, sp + 32'd4};
    else
      {e_wr, e_br, c_tgt, e_addr, e_data, e_res, e_tgt} =
        {3'b111, sp - 32'd4, fp, sp - 32'd4, operand};
    step();
  endtask

  // Bound protocol assertions count their failures
  always @(exec_stage_inst.protocol_checks.failures)
  begin
    if (exec_stage_inst.protocol_checks.failures != 0)
    begin
      $display("A bound protocol assertion failed at %0t", $time);
      stop_failed();
    end
  end

  initial
  begin
    #1 rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #2 rst = 1'b0;
    for (int r = 0; r < ALU_ROUNDS; r++)
      for (int i = 0; i < 20; i++)
        run_single(SINGLE_OPS[i]);
    run_frame(1'b0, 1'b0);
    run_single(OP_NOP);
    run_frame(1'b1, 1'b0);
    run_frame(1'b0, 1'b1);
    run_single(OP_NOP);
    run_frame(1'b1, 1'b1);
    // Stall a pending jump right after a store, then let it through
    run_single(OP_STA_L);
    op = OP_JMPA;
    operand = lcg_next();
    hold_cycles(3);
    clear_expect();
    {e_br, c_tgt, e_tgt} = {2'b11, operand};
    step();
    op = OP_NOP;
    clear_expect();
    repeat (3) step();
    if (exec_stage_inst.protocol_checks.failures == 0)
    begin
      $display("Done: no errors");
      $finish;
    end
    else
    begin
      $display("Protocol assertions failed %0d times", exec_stage_inst.protocol_checks.failures);
      stop_failed();
    end
  end

  initial
  begin
    #((PLANNED_OPS * 3 + RESET_CYCLES + 20) * 20);
    $display("Watchdog expired before the test sequence finished, the run hung");
    stop_failed();
  end

endmodule
